/* src/c128_audio_consts.svh */
`ifndef C128_AUDIO_CONSTS_SVH
`define C128_AUDIO_CONSTS_SVH

// ==============================
// FM compressor curve
// ==============================

// Slope divisor above the knee
`define COMP_F1 4

// Gain below the knee
`define COMP_A1 2

// Knee position, +1 keeps the upper segment from overflowing
`define COMP_X1 (((32767 * (`COMP_F1 - 1)) / ((`COMP_F1 * `COMP_A1) - 1)) + 1)

// Output level at the knee
`define COMP_B1 (`COMP_X1 * `COMP_A1)

// ==============================
// Mix weights
// ==============================

`define OPL_ATTEN_SHIFT 3
`define SID_DROP 2
`define DAC_SHIFT 6
`define CASS_SHIFT 9

// DigiMax channel count
`define DAC_CHANNELS 4

`endif

/* src/c128_audio_pkg.sv */
`include "c128_audio_consts.svh"

package c128_audio_pkg;

	// Signed 16-bit audio, FM path and final outputs
	typedef logic signed [15:0] sample_t;

	// Raw SID output before the low bits are dropped
	typedef logic signed [17:0] sid_sample_t;

	// One DigiMax channel and the sum of two of them
	typedef logic [7:0] dac_byte_t;
	typedef logic [8:0] dac_sum_t;

	// One bit per DAC channel, set once it has held a non-zero byte
	typedef logic [`DAC_CHANNELS-1:0] chan_mask_t;

	// DigiMax page select
	// Any value with bit 1 set maps the device to IOF
	typedef enum logic [1:0] {
		DIGIMAX_OFF = 2'd0,
		DIGIMAX_IOE = 2'd1,
		DIGIMAX_IOF = 2'd2
	} digimax_mode_e;

endpackage

/* src/digimax_dac.sv */
`include "c128_audio_consts.svh"

module digimax_dac import c128_audio_pkg::*; (
	input  logic          clk_sys,
	input  logic          RESET,
	input  digimax_mode_e digimax_mode_i,
	input  logic [2:0]    bus_addr_i,
	input  dac_byte_t     bus_data_i,
	input  logic          bus_we_i,
	input  logic          ioe_i,
	input  logic          iof_i,
	output dac_sum_t      dac_l_o,
	output dac_sum_t      dac_r_o
);

	logic       ioe_q;
	logic       iof_q;
	logic       ioe_we;
	logic       iof_we;
	logic       page_we;
	dac_byte_t  dac_q [`DAC_CHANNELS];
	chan_mask_t act_q;
	dac_byte_t  l_a;
	dac_byte_t  l_b;
	dac_byte_t  r_a;
	dac_byte_t  r_b;

	// ==============================
	// Write strobes
	// ==============================

	// Rising edge of a page select with the write enable high
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ioe_q  <= 1'b0;
			iof_q  <= 1'b0;
			ioe_we <= 1'b0;
			iof_we <= 1'b0;
		end else begin
			ioe_q  <= ioe_i;
			iof_q  <= iof_i;
			ioe_we <= ~ioe_q & ioe_i & bus_we_i;
			iof_we <= ~iof_q & iof_i & bus_we_i;
		end
	end

	assign page_we = (digimax_mode_i >= DIGIMAX_IOF) ? iof_we : ioe_we;

	// ==============================
	// Channel registers
	// ==============================

	// Addresses 4..7 of the page belong to other hardware
	always_ff @(posedge clk_sys) begin
		if (RESET || digimax_mode_i == DIGIMAX_OFF) begin
			for (int i = 0; i < `DAC_CHANNELS; i++) begin
				dac_q[i] <= '0;
			end
			act_q <= '0;
		end else if (page_we && !bus_addr_i[2]) begin
			dac_q[bus_addr_i[1:0]] <= bus_data_i;
			if (bus_data_i != '0)
				act_q[bus_addr_i[1:0]] <= 1'b1;
		end
	end

	// Guess mono, stereo or four-channel use from the activity mask
	always_comb begin
		if (act_q < 4'd2) begin
			l_a = dac_q[0];
			l_b = dac_q[0];
			r_a = dac_q[0];
			r_b = dac_q[0];
		end else if (act_q == 4'd2) begin
			l_a = dac_q[1];
			l_b = dac_q[1];
			r_a = dac_q[0];
			r_b = dac_q[0];
		end else begin
			l_a = dac_q[1];
			l_b = dac_q[2];
			r_a = dac_q[0];
			r_b = dac_q[3];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dac_l_o <= '0;
			dac_r_o <= '0;
		end else begin
			dac_l_o <= dac_sum_t'(l_a) + dac_sum_t'(l_b);
			dac_r_o <= dac_sum_t'(r_a) + dac_sum_t'(r_b);
		end
	end

endmodule

/* src/opl_compressor.sv */
`include "c128_audio_consts.svh"

module opl_compressor import c128_audio_pkg::*; (
	input  logic    clk_sys,
	input  logic    RESET,
	input  sample_t opl_sample_i,
	output sample_t opl_comp_o
);

	sample_t atten_q;

	// Piecewise-linear curve on the magnitude, sign restored afterwards
	function automatic sample_t compress(input sample_t x);
		logic [15:0] mag;
		logic [15:0] res;

		mag = x[15] ? 16'(-x) : 16'(x);
		if (mag < 16'(`COMP_X1))
			res = 16'(mag * `COMP_A1);
		else
			res = 16'(((mag - 16'(`COMP_X1)) / `COMP_F1) + `COMP_B1);
		return x[15] ? sample_t'(-res) : sample_t'(res);
	endfunction

	// ==============================
	// Stage 1 attenuation
	// ==============================

	// Take off one eighth to leave headroom for the other sources
	always_ff @(posedge clk_sys) begin
		if (RESET)
			atten_q <= '0;
		else
			atten_q <= opl_sample_i - (opl_sample_i >>> `OPL_ATTEN_SHIFT);
	end

	// ==============================
	// Stage 2 compression
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (RESET)
			opl_comp_o <= '0;
		else
			opl_comp_o <= compress(atten_q);
	end

endmodule

/* src/audio_mixer.sv */
`include "c128_audio_consts.svh"

module audio_mixer import c128_audio_pkg::*; (
	input  logic        clk_sys,
	input  logic        RESET,
	input  sample_t     opl_comp_i,
	input  sid_sample_t sid_l_i,
	input  sid_sample_t sid_r_i,
	input  dac_sum_t    dac_l_i,
	input  dac_sum_t    dac_r_i,
	input  logic        cass_snd_i,
	output sample_t     audio_l_o,
	output sample_t     audio_r_o
);

	// One bit of headroom over the output sample
	typedef logic signed [16:0] mix_t;

	mix_t sum_l_q;
	mix_t sum_r_q;

	function automatic mix_t mix_sum(input sample_t fm, input sid_sample_t sid,
			input dac_sum_t dac, input logic cass);
		mix_t fm_x;
		mix_t sid_x;
		mix_t dac_x;
		mix_t cass_x;

		fm_x   = mix_t'(fm);
		sid_x  = mix_t'(sid >>> `SID_DROP);
		dac_x  = mix_t'({dac, {`DAC_SHIFT{1'b0}}});
		cass_x = mix_t'({cass, {`CASS_SHIFT{1'b0}}});
		return fm_x + sid_x + dac_x + cass_x;
	endfunction

	// Clamp when the top two bits disagree
	function automatic sample_t saturate(input mix_t s);
		return (s[16] ^ s[15]) ? {s[16], {15{s[15]}}} : s[15:0];
	endfunction

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			sum_l_q   <= '0;
			sum_r_q   <= '0;
			audio_l_o <= '0;
			audio_r_o <= '0;
		end else begin
			sum_l_q   <= mix_sum(opl_comp_i, sid_l_i, dac_l_i, cass_snd_i);
			sum_r_q   <= mix_sum(opl_comp_i, sid_r_i, dac_r_i, cass_snd_i);
			audio_l_o <= saturate(sum_l_q);
			audio_r_o <= saturate(sum_r_q);
		end
	end

endmodule

/* src/c128_audio.sv */
module c128_audio import c128_audio_pkg::*; (
	input  logic          clk_sys,
	input  logic          RESET,

	// DigiMax page choice
	input  digimax_mode_e digimax_mode_i,

	// CPU bus
	input  logic [2:0]    bus_addr_i,
	input  dac_byte_t     bus_data_i,
	input  logic          bus_we_i,
	input  logic          ioe_i,
	input  logic          iof_i,

	// External sound sources
	input  sample_t       opl_sample_i,
	input  sid_sample_t   sid_l_i,
	input  sid_sample_t   sid_r_i,
	input  logic          cass_snd_i,

	output sample_t       audio_l_o,
	output sample_t       audio_r_o
);

	dac_sum_t dac_l;
	dac_sum_t dac_r;
	sample_t  opl_comp;

	digimax_dac u_digimax_dac (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.digimax_mode_i (digimax_mode_i),
		.bus_addr_i     (bus_addr_i),
		.bus_data_i     (bus_data_i),
		.bus_we_i       (bus_we_i),
		.ioe_i          (ioe_i),
		.iof_i          (iof_i),
		.dac_l_o        (dac_l),
		.dac_r_o        (dac_r)
	);

	// FM path is two cycles longer than SID and tape
	opl_compressor u_opl_compressor (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.opl_sample_i (opl_sample_i),
		.opl_comp_o   (opl_comp)
	);

	audio_mixer u_audio_mixer (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.opl_comp_i (opl_comp),
		.sid_l_i    (sid_l_i),
		.sid_r_i    (sid_r_i),
		.dac_l_i    (dac_l),
		.dac_r_i    (dac_r),
		.cass_snd_i (cass_snd_i),
		.audio_l_o  (audio_l_o),
		.audio_r_o  (audio_r_o)
	);

endmodule

/* bench/audio_model.svh */
`ifndef AUDIO_MODEL_SVH
`define AUDIO_MODEL_SVH

`include "c128_audio_consts.svh"

// Division rounding toward minus infinity, like an arithmetic right shift
function automatic int floor_div(input int x, input int d);
	if (x >= 0)
		return x / d;
	return -((-x + d - 1) / d);
endfunction

// FM level less one eighth of itself
function automatic int attenuated_fm(input int x);
	return x - floor_div(x, 1 << `OPL_ATTEN_SHIFT);
endfunction

// Two-segment curve on the magnitude
function automatic int compressed_fm(input int a);
	int mag;
	int res;
	mag = (a < 0) ? -a : a;
	if (mag < `COMP_X1)
		res = mag * `COMP_A1;
	else
		res = (mag - `COMP_X1) / `COMP_F1 + `COMP_B1;
	return (a < 0) ? -res : res;
endfunction

// DigiMax sums by activity mask: mono, stereo, then four channels
function automatic int left_dac_sum(input int mask, input int c0, input int c1, input int c2);
	if (mask < 2)
		return 2 * c0;
	if (mask == 2)
		return 2 * c1;
	return c1 + c2;
endfunction

function automatic int right_dac_sum(input int mask, input int c0, input int c3);
	if (mask <= 2)
		return 2 * c0;
	return c0 + c3;
endfunction

// Sum kept to 17 bits, then clamped to the 16-bit range
function automatic int mixed_output(input int fm, input int sid, input int dac, input int cass);
	int sum;
	sum = fm + floor_div(sid, 1 << `SID_DROP) + (dac << `DAC_SHIFT) + (cass << `CASS_SHIFT);
	sum = sum & 'h1ffff;
	if (sum >= 'h10000)
		sum = sum - 'h20000;
	if (sum > 32767)
		return 32767;
	if (sum < -32768)
		return -32768;
	return sum;
endfunction

`endif

/* bench/tb_c128_audio.sv */
`include "c128_audio_consts.svh"

module tb_c128_audio import c128_audio_pkg::*; ();

	localparam int SETTLE_CYCLES = 10;
	localparam int WRITE_CYCLES = 4;
	localparam int FM_COUNT = 200;
	localparam int MIX_COUNT = 40;
	// Reset, FM sweep, mode and qualification writes, mix loop, then a margin
	localparam int CYCLE_LIMIT = 4 + SETTLE_CYCLES + FM_COUNT * SETTLE_CYCLES
		+ 20 * (WRITE_CYCLES + SETTLE_CYCLES) + MIX_COUNT * (WRITE_CYCLES + SETTLE_CYCLES) + 500;

	logic          clk_sys;
	logic          RESET;
	digimax_mode_e digimax_mode;
	logic [2:0]    bus_addr;
	dac_byte_t     bus_data;
	logic          bus_we;
	logic          ioe;
	logic          iof;
	sample_t       opl_sample;
	sid_sample_t   sid_l;
	sid_sample_t   sid_r;
	logic          cass_snd;
	sample_t       audio_l;
	sample_t       audio_r;

	// Expected DigiMax state
	int dac_ch [4];
	int act_mask;
	int seed;
	int cycles = 0;
	int checks = 0;
	int errors = 0;
	int test_checks = 0;
	int test_errors = 0;
	sample_t edge_fm [8] = '{16'sd0, 16'sd100, 16'sd16048, 16'sd16056,
		16'sd32767, -16'sd100, -16'sd16056, 16'sh8000};

	`include "audio_model.svh"

	c128_audio dut (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.digimax_mode_i (digimax_mode),
		.bus_addr_i     (bus_addr),
		.bus_data_i     (bus_data),
		.bus_we_i       (bus_we),
		.ioe_i          (ioe),
		.iof_i          (iof),
		.opl_sample_i   (opl_sample),
		.sid_l_i        (sid_l),
		.sid_r_i        (sid_r),
		.cass_snd_i     (cass_snd),
		.audio_l_o      (audio_l),
		.audio_r_o      (audio_r)
	);

	initial clk_sys = 1'b0;
	always #50 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// ==============================
	// Stimulus tasks
	// ==============================

	task automatic clear_dac_model();
		for (int c = 0; c < 4; c++)
			dac_ch[c] = 0;
		act_mask = 0;
	endtask

	task automatic set_mode(input digimax_mode_e m);
		digimax_mode = m;
		if (m == DIGIMAX_OFF)
			clear_dac_model();
		@(negedge clk_sys);
	endtask

	// Raise one page select with address and data held through the store
	task automatic write_bus(input logic [2:0] addr, input dac_byte_t data,
			input logic we, input logic use_iof);
		int ch;
		bus_addr = addr;
		bus_data = data;
		bus_we = we;
		if (use_iof)
			iof = 1'b1;
		else
			ioe = 1'b1;
		repeat (2) @(negedge clk_sys);
		ioe = 1'b0;
		iof = 1'b0;
		bus_we = 1'b0;
		repeat (2) @(negedge clk_sys);
		ch = int'(addr[1:0]);
		if (digimax_mode != DIGIMAX_OFF && we && !addr[2]
				&& use_iof == (digimax_mode >= DIGIMAX_IOF)) begin
			dac_ch[ch] = int'(data);
			if (data != 8'd0)
				act_mask = act_mask | (1 << ch);
		end
	endtask

	task automatic settle_and_check(input string what);
		int fm;
		int exp_l;
		int exp_r;
		repeat (SETTLE_CYCLES) @(negedge clk_sys);
		fm = compressed_fm(attenuated_fm(int'(opl_sample)));
		exp_l = mixed_output(fm, int'(sid_l),
			left_dac_sum(act_mask, dac_ch[0], dac_ch[1], dac_ch[2]), int'(cass_snd));
		exp_r = mixed_output(fm, int'(sid_r),
			right_dac_sum(act_mask, dac_ch[0], dac_ch[3]), int'(cass_snd));
		checks++;
		test_checks++;
		if (int'(audio_l) != exp_l || int'(audio_r) != exp_r) begin
			$display("Error at %0t: %s, outputs %0d/%0d, expected %0d/%0d",
				$time, what, audio_l, audio_r, exp_l, exp_r);
			errors++;
			test_errors++;
		end
	endtask

	// Both outputs against one fixed value
	task automatic expect_both(input string what, input int value);
		checks++;
		test_checks++;
		if (audio_l !== sample_t'(value) || audio_r !== sample_t'(value)) begin
			$display("Error at %0t: %s, outputs %0d/%0d, expected %0d",
				$time, what, audio_l, audio_r, value);
			errors++;
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		$display("Test %s done: %0d checks, %0d errors", name, test_checks, test_errors);
		test_checks = 0;
		test_errors = 0;
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		seed = 80;
		RESET = 1'b1;
		digimax_mode = DIGIMAX_OFF;
		bus_addr = 3'd0;
		bus_data = 8'd0;
		bus_we = 1'b0;
		ioe = 1'b0;
		iof = 1'b0;
		// Live sources during reset so that only the reset keeps the outputs at zero
		opl_sample = 16'sh4000;
		sid_l = 18'sd4000;
		sid_r = -18'sd4000;
		cass_snd = 1'b1;
		clear_dac_model();
		repeat (4) @(negedge clk_sys);
		RESET = 1'b0;
		opl_sample = 16'sd0;
		sid_l = 18'sd0;
		sid_r = 18'sd0;
		cass_snd = 1'b0;
		expect_both("reset release", 0);
		settle_and_check("reset");
		finish_test("reset");

		// Edge values first to cover the knee and both signs
		set_mode(DIGIMAX_OFF);
		for (int i = 0; i < FM_COUNT; i++) begin
			if (i < 8)
				opl_sample = edge_fm[i];
			else
				opl_sample = 16'($random(seed));
			settle_and_check("FM compression");
		end
		finish_test("FM compression");

		set_mode(DIGIMAX_IOE);
		write_bus(3'd0, 8'($random(seed)) | 8'h01, 1'b1, 1'b0);
		settle_and_check("mono");
		set_mode(DIGIMAX_OFF);
		set_mode(DIGIMAX_IOF);
		write_bus(3'd1, 8'($random(seed)) | 8'h01, 1'b1, 1'b1);
		settle_and_check("stereo");
		for (int k = 0; k < 4; k++)
			write_bus(3'(k), 8'($random(seed)) | 8'h01, 1'b1, 1'b1);
		settle_and_check("four-channel");
		finish_test("mode guess");

		// Writes that must leave the channels alone on the IOF mapping
		for (int k = 0; k < 4; k++)
			write_bus(3'(k), 8'(dac_ch[k] ^ 'h5a), 1'b1, 1'b0);
		settle_and_check("unselected page");
		for (int k = 0; k < 4; k++)
			write_bus(3'(4 + k), 8'(dac_ch[k] ^ 'h5a), 1'b1, 1'b1);
		settle_and_check("address bit 2");
		for (int k = 0; k < 4; k++)
			write_bus(3'(k), 8'(dac_ch[k] ^ 'h5a), 1'b0, 1'b1);
		settle_and_check("write enable low");
		set_mode(DIGIMAX_OFF);
		settle_and_check("mode off");
		finish_test("write qualification");

		set_mode(DIGIMAX_IOE);
		for (int i = 0; i < MIX_COUNT; i++) begin
			write_bus(3'($random(seed) & 3), 8'($random(seed)), 1'b1, 1'b0);
			opl_sample = 16'($random(seed));
			sid_l = 18'($random(seed));
			sid_r = 18'($random(seed));
			cass_snd = 1'($random(seed));
			settle_and_check("full mix");
		end
		set_mode(DIGIMAX_OFF);
		opl_sample = 16'sh7fff;
		sid_l = 18'sh1ffff;
		sid_r = 18'sh1ffff;
		cass_snd = 1'b1;
		settle_and_check("positive clamp");
		expect_both("positive clamp", 32767);
		opl_sample = 16'sh8000;
		sid_l = 18'sh20000;
		sid_r = 18'sh20000;
		cass_snd = 1'b0;
		settle_and_check("negative clamp");
		expect_both("negative clamp", -32768);
		finish_test("full mix");

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* all.f */
+incdir+src
+incdir+bench
src/c128_audio_pkg.sv
src/digimax_dac.sv
src/opl_compressor.sv
src/audio_mixer.sv
src/c128_audio.sv
bench/tb_c128_audio.sv

/* run.sh */
#!/bin/sh
# Build and run the c128_audio testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_c128_audio -f all.f --Mdir obj_dir -o tb_c128_audio
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_c128_audio > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Simulation PASSED" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
